//--- design/led_matrix_pkg.sv
package led_matrix_pkg;

    // panel geometry
    localparam int PANEL_WIDTH       = 16;
    localparam int PANEL_HALF_HEIGHT = 4;  // rows per half
    localparam int PANEL_HEIGHT      = 2 * PANEL_HALF_HEIGHT;
    localparam int PANEL_PIXELS      = PANEL_WIDTH * PANEL_HEIGHT;
    localparam int COL_BITS          = 4;
    localparam int ROW_BITS          = 2;  // scanned row, shared by both halves
    localparam int FB_ADDR_BITS      = 7;
    localparam int COLOR_BITS        = 4;  // also the number of brightness planes
    localparam int PLANE_BITS        = 2;

    // timing
    localparam int OE_BASE_CYCLES     = 4;  // plane p lit for base << p
    localparam int OE_CNT_BITS        = $clog2(OE_BASE_CYCLES << (COLOR_BITS - 1));
    localparam int UART_TICKS_PER_BIT = 8;
    localparam int UART_TICK_BITS     = $clog2(UART_TICKS_PER_BIT);

    typedef struct packed {
        logic [COLOR_BITS-1:0] red;
        logic [COLOR_BITS-1:0] green;
        logic [COLOR_BITS-1:0] blue;
    } pixel_t;

    typedef struct packed {
        pixel_t top;
        pixel_t bottom;
    } pixel_pair_t;

    // one colour bit per channel, also used as channel enables
    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } rgb_bits_t;

    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [FB_ADDR_BITS-1:0] adr;
        pixel_t                  dat;
    } wb_req_t;

    typedef enum logic [7:0] {
        OP_SET_RGB_EN   = 8'h01,  // + enable byte, bit 0 red
        OP_SET_PLANE_EN = 8'h02,  // + plane mask byte
        OP_WRITE_PIXEL  = 8'h03,  // + col, row, hi, lo
        OP_FILL         = 8'h04   // + hi, lo
    } cmd_opcode_t;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_ARGS,
        CTRL_WRITE,
        CTRL_FILL
    } ctrl_state_t;

    typedef enum logic [1:0] {
        SCAN_FETCH,
        SCAN_SHIFT,
        SCAN_LATCH,
        SCAN_DISPLAY
    } scan_state_t;

endpackage

//--- design/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic       clk_in,
    input  logic       rst_n,
    input  logic       rx_line,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    logic [1:0] sync_q;  // two-flop synchroniser
    logic       line_s;
    logic       active;  // frame in progress
    logic       sample;  // mid-bit strobe
    logic [3:0] bit_idx; // 0 start, 1..8 data, 9 stop
    logic [led_matrix_pkg::UART_TICK_BITS-1:0] tick;

    assign line_s = sync_q[1];
    assign sample = active && (32'(tick) == led_matrix_pkg::UART_TICKS_PER_BIT - 1);

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            sync_q   <= 2'b11; // line idles high
            active   <= 1'b0;
            tick     <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            sync_q   <= {sync_q[0], rx_line};
            rx_valid <= 1'b0;
            if (!active) begin
                if (!line_s) begin
                    // start edge, first wrap lands half a bit later
                    active  <= 1'b1;
                    tick    <= led_matrix_pkg::UART_TICK_BITS'(
                                   led_matrix_pkg::UART_TICKS_PER_BIT / 2);
                    bit_idx <= '0;
                end
            end else if (sample) begin
                tick    <= '0;
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == 4'd0 && line_s) begin
                    active <= 1'b0;    // glitch, not a real start bit
                end
                if (bit_idx == 4'd9) begin
                    active   <= 1'b0;
                    rx_valid <= line_s; // framing error drops the byte
                end
            end else begin
                tick <= tick + 1'b1;
            end
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk_in) begin
        if (sample && bit_idx != 4'd0 && bit_idx != 4'd9) begin
            rx_byte <= {line_s, rx_byte[7:1]};
        end
    end

endmodule

//--- design/cmd_controller.sv
`timescale 1ns/1ps

module cmd_controller (
    input  logic                                  clk_in,
    input  logic                                  rst_n,
    input  logic [7:0]                            rx_byte,
    input  logic                                  rx_valid,
    output led_matrix_pkg::wb_req_t               wb_req,
    input  logic                                  wb_ack,
    output led_matrix_pkg::rgb_bits_t             rgb_enable,
    output logic [led_matrix_pkg::COLOR_BITS-1:0] plane_enable,
    output logic                                  busy
);

    led_matrix_pkg::ctrl_state_t state;
    led_matrix_pkg::cmd_opcode_t opcode;
    led_matrix_pkg::pixel_t      rx_pixel;
    logic [1:0] arg_idx;
    logic [1:0] arg_last;  // argument count minus one
    logic       fill_mode;
    logic [7:0] prev_byte; // high colour byte when the low one arrives
    logic [led_matrix_pkg::COL_BITS-1:0] col_q;
    logic [led_matrix_pkg::FB_ADDR_BITS-led_matrix_pkg::COL_BITS-1:0] row_q;

    assign busy     = (state != led_matrix_pkg::CTRL_IDLE);
    assign rx_pixel = {prev_byte[3:0], rx_byte}; // red nibble, then green and blue

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            state        <= led_matrix_pkg::CTRL_IDLE;
            opcode       <= led_matrix_pkg::OP_SET_RGB_EN;
            arg_idx      <= '0;
            arg_last     <= '0;
            fill_mode    <= 1'b0;
            wb_req       <= '0;
            rgb_enable   <= '1;
            plane_enable <= '1;
        end else begin
            case (state)
                led_matrix_pkg::CTRL_IDLE: begin
                    if (rx_valid) begin
                        opcode  <= led_matrix_pkg::cmd_opcode_t'(rx_byte);
                        arg_idx <= '0;
                        state   <= led_matrix_pkg::CTRL_ARGS;
                        case (rx_byte)
                            led_matrix_pkg::OP_SET_RGB_EN,
                            led_matrix_pkg::OP_SET_PLANE_EN: arg_last <= 2'd0;
                            led_matrix_pkg::OP_WRITE_PIXEL:  arg_last <= 2'd3;
                            led_matrix_pkg::OP_FILL:         arg_last <= 2'd1;
                            default: state <= led_matrix_pkg::CTRL_IDLE; // unknown, dropped
                        endcase
                    end
                end
                led_matrix_pkg::CTRL_ARGS: begin
                    if (rx_valid && arg_idx != arg_last) begin
                        arg_idx <= arg_idx + 1'b1;
                    end else if (rx_valid) begin
                        state <= led_matrix_pkg::CTRL_IDLE;
                        case (opcode)
                            led_matrix_pkg::OP_SET_RGB_EN: begin
                                rgb_enable <= '{r: rx_byte[0], g: rx_byte[1], b: rx_byte[2]};
                            end
                            led_matrix_pkg::OP_SET_PLANE_EN: begin
                                plane_enable <= rx_byte[led_matrix_pkg::COLOR_BITS-1:0];
                            end
                            led_matrix_pkg::OP_WRITE_PIXEL: begin
                                wb_req    <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1,
                                               adr: {row_q, col_q}, dat: rx_pixel};
                                fill_mode <= 1'b0;
                                state     <= led_matrix_pkg::CTRL_WRITE;
                            end
                            default: begin // fill starts at address 0
                                wb_req    <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1,
                                               adr: '0, dat: rx_pixel};
                                fill_mode <= 1'b1;
                                state     <= led_matrix_pkg::CTRL_WRITE;
                            end
                        endcase
                    end
                end
                led_matrix_pkg::CTRL_WRITE: begin
                    if (wb_ack) begin
                        wb_req.cyc <= 1'b0;
                        wb_req.stb <= 1'b0;
                        wb_req.we  <= 1'b0;
                        if (fill_mode && 32'(wb_req.adr) != led_matrix_pkg::PANEL_PIXELS - 1) begin
                            state <= led_matrix_pkg::CTRL_FILL;
                        end else begin
                            state <= led_matrix_pkg::CTRL_IDLE;
                        end
                    end
                end
                default: begin
                    // one idle cycle between fill writes
                    wb_req.cyc <= 1'b1;
                    wb_req.stb <= 1'b1;
                    wb_req.we  <= 1'b1;
                    wb_req.adr <= wb_req.adr + 1'b1;
                    state      <= led_matrix_pkg::CTRL_WRITE;
                end
            endcase
        end
    end

    // argument bytes ahead of the last one
    always_ff @(posedge clk_in) begin
        if (state == led_matrix_pkg::CTRL_ARGS && rx_valid && arg_idx != arg_last) begin
            prev_byte <= rx_byte;
            if (arg_idx == 2'd0) col_q <= rx_byte[led_matrix_pkg::COL_BITS-1:0];
            if (arg_idx == 2'd1) row_q <= rx_byte[$bits(row_q)-1:0];
        end
    end

endmodule

//--- design/framebuffer.sv
`timescale 1ns/1ps

module framebuffer (
    input  logic                                    clk_in,
    input  logic                                    rst_n,
    input  led_matrix_pkg::wb_req_t                 wb_req,
    output logic                                    wb_ack,
    input  logic                                    rd_en,
    input  logic [led_matrix_pkg::FB_ADDR_BITS-1:0] rd_addr,
    output led_matrix_pkg::pixel_t                  rd_data
);

    led_matrix_pkg::pixel_t mem [led_matrix_pkg::PANEL_PIXELS];
    logic                   wb_hit; // new request, not yet acked

    assign wb_hit = wb_req.cyc && wb_req.stb && !wb_ack;

    // single-cycle ack, one cycle after the request is seen
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_hit;
        end
    end

    always_ff @(posedge clk_in) begin
        if (wb_hit && wb_req.we) mem[wb_req.adr] <= wb_req.dat; // lands with ack
        if (rd_en) rd_data <= mem[rd_addr];
    end

endmodule

//--- design/framebuffer_fetch.sv
`timescale 1ns/1ps

module framebuffer_fetch (
    input  logic                                    clk_in,
    input  logic                                    rst_n,
    input  logic                                    fetch_req,
    input  logic [led_matrix_pkg::COL_BITS-1:0]     column,
    input  logic [led_matrix_pkg::ROW_BITS-1:0]     row,
    output logic                                    rd_en,
    output logic [led_matrix_pkg::FB_ADDR_BITS-1:0] rd_addr,
    input  led_matrix_pkg::pixel_t                  rd_data,
    output led_matrix_pkg::pixel_pair_t             pair,
    output logic                                    pair_valid
);

    logic [led_matrix_pkg::FB_ADDR_BITS-1:0] top_addr;
    logic [led_matrix_pkg::FB_ADDR_BITS-1:0] bottom_addr;
    logic bottom_rd;   // bottom read out, top data on rd_data
    logic bottom_back; // bottom data on rd_data

    assign top_addr = led_matrix_pkg::FB_ADDR_BITS'(
                          32'(row) * led_matrix_pkg::PANEL_WIDTH + 32'(column));

    // top read goes out with the request itself
    assign rd_en   = fetch_req | bottom_rd;
    assign rd_addr = bottom_rd ? bottom_addr : top_addr;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            bottom_rd   <= 1'b0;
            bottom_back <= 1'b0;
            pair_valid  <= 1'b0;
        end else begin
            bottom_rd   <= fetch_req;
            bottom_back <= bottom_rd;
            pair_valid  <= bottom_back;
        end
    end

    always_ff @(posedge clk_in) begin
        if (fetch_req) begin
            bottom_addr <= top_addr + led_matrix_pkg::FB_ADDR_BITS'(
                               led_matrix_pkg::PANEL_HALF_HEIGHT * led_matrix_pkg::PANEL_WIDTH);
        end
        if (bottom_rd) pair.top <= rd_data;
        if (bottom_back) pair.bottom <= rd_data;
    end

endmodule

//--- design/matrix_scan.sv
`timescale 1ns/1ps

module matrix_scan (
    input  logic                                  clk_in,
    input  logic                                  rst_n,
    input  led_matrix_pkg::rgb_bits_t             rgb_enable,
    input  logic [led_matrix_pkg::COLOR_BITS-1:0] plane_enable,
    output logic                                  fetch_req,
    output logic [led_matrix_pkg::COL_BITS-1:0]   column,
    output logic [led_matrix_pkg::ROW_BITS-1:0]   row,
    input  led_matrix_pkg::pixel_pair_t           pair,
    input  logic                                  pair_valid,
    output led_matrix_pkg::rgb_bits_t             rgb_top,
    output led_matrix_pkg::rgb_bits_t             rgb_bottom,
    output logic                                  clk_pixel,
    output logic                                  row_latch,
    output logic                                  output_enable,
    output logic [led_matrix_pkg::ROW_BITS-1:0]   row_address
);

    led_matrix_pkg::scan_state_t state;
    led_matrix_pkg::rgb_bits_t   chan_en; // channel enables gated by this plane
    logic [led_matrix_pkg::PLANE_BITS-1:0]  plane;
    logic [led_matrix_pkg::OE_CNT_BITS-1:0] oe_cnt;
    logic fetch_wait; // request out, pair not back yet

    function automatic led_matrix_pkg::rgb_bits_t plane_bits(
        input led_matrix_pkg::pixel_t                px,
        input logic [led_matrix_pkg::PLANE_BITS-1:0] p,
        input led_matrix_pkg::rgb_bits_t             en
    );
        plane_bits.r = px.red[p] & en.r;
        plane_bits.g = px.green[p] & en.g;
        plane_bits.b = px.blue[p] & en.b;
    endfunction

    assign chan_en   = rgb_enable & {3{plane_enable[plane]}};
    assign fetch_req = (state == led_matrix_pkg::SCAN_FETCH) && !fetch_wait;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            state         <= led_matrix_pkg::SCAN_FETCH;
            fetch_wait    <= 1'b0;
            column        <= '0;
            row           <= '0;
            plane         <= '0;
            oe_cnt        <= '0;
            clk_pixel     <= 1'b0;
            row_latch     <= 1'b0;
            output_enable <= 1'b0;
            row_address   <= '0;
            rgb_top       <= '0;
            rgb_bottom    <= '0;
        end else begin
            case (state)
                led_matrix_pkg::SCAN_FETCH: begin
                    if (fetch_req) fetch_wait <= 1'b1;
                    if (pair_valid) begin
                        fetch_wait <= 1'b0;
                        rgb_top    <= plane_bits(pair.top, plane, chan_en);
                        rgb_bottom <= plane_bits(pair.bottom, plane, chan_en);
                        state      <= led_matrix_pkg::SCAN_SHIFT;
                    end
                end
                led_matrix_pkg::SCAN_SHIFT: begin
                    clk_pixel <= !clk_pixel; // one cycle high, low again in next fetch
                    if (clk_pixel) begin
                        if (32'(column) == led_matrix_pkg::PANEL_WIDTH - 1) begin
                            column <= '0;
                            state  <= led_matrix_pkg::SCAN_LATCH;
                        end else begin
                            column <= column + 1'b1;
                            state  <= led_matrix_pkg::SCAN_FETCH;
                        end
                    end
                end
                led_matrix_pkg::SCAN_LATCH: begin
                    row_latch   <= 1'b1;
                    row_address <= row;
                    oe_cnt      <= led_matrix_pkg::OE_CNT_BITS'(
                                       (led_matrix_pkg::OE_BASE_CYCLES << plane) - 1);
                    state       <= led_matrix_pkg::SCAN_DISPLAY;
                end
                default: begin
                    row_latch <= 1'b0;
                    if (row_latch) begin
                        output_enable <= 1'b1; // oe only after latch drops
                    end else if (oe_cnt == '0) begin
                        output_enable <= 1'b0;
                        state         <= led_matrix_pkg::SCAN_FETCH;
                        if (32'(plane) == led_matrix_pkg::COLOR_BITS - 1) begin
                            plane <= '0;
                            if (32'(row) == led_matrix_pkg::PANEL_HALF_HEIGHT - 1) begin
                                row <= '0;
                            end else begin
                                row <= row + 1'b1;
                            end
                        end else begin
                            plane <= plane + 1'b1;
                        end
                    end else begin
                        oe_cnt <= oe_cnt - 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

//--- design/led_matrix_top.sv
`timescale 1ns/1ps

module led_matrix_top (
    input  logic                                clk_in,
    input  logic                                rst_n,
    input  logic                                uart_rx_line,
    output led_matrix_pkg::rgb_bits_t           rgb_top,
    output led_matrix_pkg::rgb_bits_t           rgb_bottom,
    output logic                                clk_pixel,
    output logic                                row_latch,
    output logic                                output_enable,
    output logic [led_matrix_pkg::ROW_BITS-1:0] row_address,
    output logic                                busy
);

    logic [7:0]                              rx_byte;
    logic                                    rx_valid;
    led_matrix_pkg::wb_req_t                 wb_req;
    logic                                    wb_ack;
    led_matrix_pkg::rgb_bits_t               rgb_enable;
    logic [led_matrix_pkg::COLOR_BITS-1:0]   plane_enable;
    logic                                    fetch_req;
    logic [led_matrix_pkg::COL_BITS-1:0]     column;
    logic [led_matrix_pkg::ROW_BITS-1:0]     row;
    led_matrix_pkg::pixel_pair_t             pair;
    logic                                    pair_valid;
    logic                                    rd_en;
    logic [led_matrix_pkg::FB_ADDR_BITS-1:0] rd_addr;
    led_matrix_pkg::pixel_t                  rd_data;

    uart_rx u_uart_rx (
        .clk_in   (clk_in),
        .rst_n    (rst_n),
        .rx_line  (uart_rx_line),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    cmd_controller u_ctrl (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid),
        .wb_req       (wb_req),
        .wb_ack       (wb_ack),
        .rgb_enable   (rgb_enable),
        .plane_enable (plane_enable),
        .busy         (busy)
    );

    framebuffer u_fb (
        .clk_in  (clk_in),
        .rst_n   (rst_n),
        .wb_req  (wb_req),
        .wb_ack  (wb_ack),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    framebuffer_fetch u_fetch (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .fetch_req  (fetch_req),
        .column     (column),
        .row        (row),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .pair       (pair),
        .pair_valid (pair_valid)
    );

    matrix_scan u_scan (
        .clk_in        (clk_in),
        .rst_n         (rst_n),
        .rgb_enable    (rgb_enable),
        .plane_enable  (plane_enable),
        .fetch_req     (fetch_req),
        .column        (column),
        .row           (row),
        .pair          (pair),
        .pair_valid    (pair_valid),
        .rgb_top       (rgb_top),
        .rgb_bottom    (rgb_bottom),
        .clk_pixel     (clk_pixel),
        .row_latch     (row_latch),
        .output_enable (output_enable),
        .row_address   (row_address)
    );

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_in,
    output logic rst_n
);

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in; // 10 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk_in);
        #1 rst_n = 1'b1;
    end

endmodule

//--- bench/led_matrix_checker.sv
`timescale 1ns/1ps

module led_matrix_checker (
    input logic                    clk_in,
    input logic                    rst_n,
    input logic                    clk_pixel,
    input logic                    row_latch,
    input logic                    output_enable,
    input led_matrix_pkg::wb_req_t wb_req,
    input logic                    wb_ack
);

    // panel must be dark while shifting or latching
    oe_dark: assert property (@(posedge clk_in) disable iff (!rst_n)
        output_enable |-> !(clk_pixel || row_latch))
        else $error("output_enable high during clk_pixel or row_latch");

    latch_pulse: assert property (@(posedge clk_in) disable iff (!rst_n)
        $rose(row_latch) |=> !row_latch)
        else $error("row_latch held longer than one cycle");

    ack_in_cycle: assert property (@(posedge clk_in) disable iff (!rst_n)
        wb_ack |-> (wb_req.cyc && wb_req.stb))
        else $error("wb_ack without cyc and stb");

    // request held until the slave answers
    req_stable: assert property (@(posedge clk_in) disable iff (!rst_n)
        (wb_req.stb && !wb_ack) |=> $stable(wb_req))
        else $error("wb_req changed while waiting for ack");

endmodule

bind led_matrix_top led_matrix_checker u_checker (
    .clk_in        (clk_in),
    .rst_n         (rst_n),
    .clk_pixel     (clk_pixel),
    .row_latch     (row_latch),
    .output_enable (output_enable),
    .wb_req        (wb_req),
    .wb_ack        (wb_ack)
);

//--- bench/tb_led_matrix.sv
`timescale 1ns/1ps

module tb_led_matrix;

    localparam int W          = led_matrix_pkg::PANEL_WIDTH;
    localparam int HALF       = led_matrix_pkg::PANEL_HALF_HEIGHT;
    localparam int PLANES     = led_matrix_pkg::COLOR_BITS;
    localparam int FRAME_LEN  = HALF * PLANES; // latches per frame
    localparam int WAIT_LIMIT = 5000;          // cycles, two frames and then some

    logic                                clk_in;
    logic                                rst_n;
    logic                                uart_rx_line;
    led_matrix_pkg::rgb_bits_t           rgb_top;
    led_matrix_pkg::rgb_bits_t           rgb_bottom;
    logic                                clk_pixel;
    logic                                row_latch;
    logic                                output_enable;
    logic [led_matrix_pkg::ROW_BITS-1:0] row_address;
    logic                                busy;

    logic [7:0]                            tdata [0:255];
    led_matrix_pkg::pixel_t                fb_model [led_matrix_pkg::PANEL_PIXELS];
    led_matrix_pkg::pixel_t                seen [led_matrix_pkg::PANEL_PIXELS];
    led_matrix_pkg::rgb_bits_t             rgb_en_model;
    logic [PLANES-1:0]                     plane_en_model;
    led_matrix_pkg::rgb_bits_t             top_q [W];
    led_matrix_pkg::rgb_bits_t             bot_q [W];
    int   errors = 0;
    int   shifts = 0;
    int   latches = 0;
    int   oe_len = 0;
    int   oe_pulses = 0; // display pulses since the last latch
    int   check_first = 0; // latch indices under check
    int   check_last = -1;
    int   tests_run = 0;
    int   tests_failed = 0;
    logic timed_out = 1'b0;

    tb_clock_gen u_clk (.clk_in(clk_in), .rst_n(rst_n));

    led_matrix_top uut (
        .clk_in        (clk_in),
        .rst_n         (rst_n),
        .uart_rx_line  (uart_rx_line),
        .rgb_top       (rgb_top),
        .rgb_bottom    (rgb_bottom),
        .clk_pixel     (clk_pixel),
        .row_latch     (row_latch),
        .output_enable (output_enable),
        .row_address   (row_address),
        .busy          (busy)
    );

    task automatic compare_bits(input led_matrix_pkg::rgb_bits_t got,
                                input led_matrix_pkg::rgb_bits_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_pixel(input led_matrix_pkg::pixel_t got,
                                 input led_matrix_pkg::pixel_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string what);
        if (got != exp) begin
            errors++;
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // bit p of each channel, gated by the plane and channel enables
    function automatic led_matrix_pkg::rgb_bits_t expect_bits(
        input led_matrix_pkg::pixel_t px, input int p);
        led_matrix_pkg::rgb_bits_t bits;
        bits.r = plane_en_model[p] & rgb_en_model.r & px.red[p];
        bits.g = plane_en_model[p] & rgb_en_model.g & px.green[p];
        bits.b = plane_en_model[p] & rgb_en_model.b & px.blue[p];
        return bits;
    endfunction

    function automatic led_matrix_pkg::pixel_t expect_pixel(input led_matrix_pkg::pixel_t px);
        led_matrix_pkg::pixel_t m;
        m.red   = px.red & plane_en_model & {PLANES{rgb_en_model.r}};
        m.green = px.green & plane_en_model & {PLANES{rgb_en_model.g}};
        m.blue  = px.blue & plane_en_model & {PLANES{rgb_en_model.b}};
        return m;
    endfunction

    task automatic store_plane(input int a, input int p, input led_matrix_pkg::rgb_bits_t bits);
        seen[a].red[p]   = bits.r;
        seen[a].green[p] = bits.g;
        seen[a].blue[p]  = bits.b;
    endtask

    task automatic row_plane_done();
        int p;
        int r;
        int a;
        p = latches % PLANES;
        r = (latches / PLANES) % HALF;
        compare_count(shifts, W, "clk_pixel pulses per latch");
        compare_count(int'(row_address), r, "row_address");
        if (latches > 0) begin
            compare_count(oe_pulses, 1, "output_enable pulses per latch");
        end
        if (latches >= check_first && latches <= check_last) begin
            for (int c = 0; c < W; c++) begin
                a = r * W + c;
                compare_bits(top_q[c], expect_bits(fb_model[a], p),
                             $sformatf("top row %0d col %0d plane %0d", r, c, p));
                compare_bits(bot_q[c], expect_bits(fb_model[a + HALF * W], p),
                             $sformatf("bottom row %0d col %0d plane %0d", r + HALF, c, p));
                store_plane(a, p, top_q[c]);
                store_plane(a + HALF * W, p, bot_q[c]);
            end
        end
        shifts = 0;
        oe_pulses = 0;
        latches++;
    endtask

    // scan monitor, samples in the middle of the clock period
    always @(negedge clk_in) begin
        if (rst_n) begin
            if (clk_pixel) begin
                if (shifts < W) begin
                    top_q[shifts] = rgb_top;
                    bot_q[shifts] = rgb_bottom;
                end
                shifts++;
            end
            if (output_enable) begin
                oe_len++;
            end else if (oe_len != 0) begin
                compare_count(oe_len, led_matrix_pkg::OE_BASE_CYCLES << ((latches - 1) % PLANES),
                              "output_enable length");
                oe_len = 0;
                oe_pulses++;
            end
            if (row_latch) row_plane_done();
        end
    end

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0}; // stop, data, start
        for (int i = 0; i < 10; i++) begin
            uart_rx_line = frame[i];
            repeat (led_matrix_pkg::UART_TICKS_PER_BIT) @(posedge clk_in);
            #1;
        end
    endtask

    task automatic wait_idle(input string what);
        int n;
        n = 0;
        while (busy && n < WAIT_LIMIT) begin
            @(posedge clk_in);
            #1;
            n++;
        end
        if (busy) begin
            $display("timeout at %0t: busy stayed high before %s", $time, what);
            timed_out = 1'b1;
        end
    endtask

    // track what the command should have done
    task automatic apply_model(input int at);
        int a;
        case (tdata[at])
            led_matrix_pkg::OP_SET_RGB_EN: begin
                rgb_en_model = '{r: tdata[at+1][0], g: tdata[at+1][1], b: tdata[at+1][2]};
            end
            led_matrix_pkg::OP_SET_PLANE_EN: plane_en_model = tdata[at+1][PLANES-1:0];
            led_matrix_pkg::OP_WRITE_PIXEL: begin
                a = int'(tdata[at+2][2:0]) * W + int'(tdata[at+1][3:0]);
                fb_model[a] = {tdata[at+3][3:0], tdata[at+4]};
            end
            led_matrix_pkg::OP_FILL: begin
                compare_flag(busy, 1'b1, "busy during fill"); // far from done yet
                for (int i = 0; i < led_matrix_pkg::PANEL_PIXELS; i++) begin
                    fb_model[i] = {tdata[at+1][3:0], tdata[at+2]};
                end
            end
            default: begin
                // unknown opcodes leave the panel alone
                compare_flag(busy, 1'b0, "busy after unknown opcode");
            end
        endcase
    endtask

    task automatic check_frame(input int test_id);
        int n;
        int err_before;
        err_before = errors;
        wait_idle("frame check");
        if (!timed_out) begin
            foreach (seen[i]) seen[i] = '0;
            check_first = (latches / FRAME_LEN + 1) * FRAME_LEN; // next whole frame
            check_last  = check_first + FRAME_LEN - 1;
            n = 0;
            while (latches <= check_last && n < WAIT_LIMIT) begin
                @(posedge clk_in);
                #1;
                n++;
            end
            if (latches <= check_last) begin
                $display("timeout at %0t: frame for test %0d never completed", $time, test_id);
                timed_out = 1'b1;
            end else begin
                foreach (seen[i]) begin
                    compare_pixel(seen[i], expect_pixel(fb_model[i]),
                                  $sformatf("pixel at address %0d", i));
                end
            end
        end
        tests_run++;
        if (errors != err_before || timed_out) tests_failed++;
        $display("test %0d: %s, %0d errors", test_id,
                 (errors == err_before && !timed_out) ? "ok" : "FAILED", errors - err_before);
    endtask

    initial begin
        int at;
        int n;
        uart_rx_line   = 1'b1;
        rgb_en_model   = '1;
        plane_en_model = '1;
        foreach (fb_model[i]) fb_model[i] = '0;
        $readmemh("bench/led_matrix_testdata.txt", tdata);
        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            @(posedge clk_in);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout at %0t: reset never released", $time);
            timed_out = 1'b1;
        end
        @(posedge clk_in);
        #1;
        at = 0;
        while (at < 250 && tdata[at] !== 8'hff && !timed_out) begin
            n = int'(tdata[at]);
            if (n == 0) begin
                check_frame(int'(tdata[at+1]));
                at += 2;
            end else begin
                wait_idle("command");
                if (!timed_out) begin
                    for (int i = 1; i <= n; i++) send_byte(tdata[at+i]);
                    apply_model(at + 1);
                end
                at += n + 1;
            end
        end
        $display("%0d tests run, %0d failed, %0d errors, %0d latches",
                 tests_run, tests_failed, errors, latches);
        if (errors == 0 && !timed_out && tests_run > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sim.f
design/led_matrix_pkg.sv
design/uart_rx.sv
design/cmd_controller.sv
design/framebuffer.sv
design/framebuffer_fetch.sv
design/matrix_scan.sv
design/led_matrix_top.sv
bench/tb_clock_gen.sv
bench/led_matrix_checker.sv
bench/tb_led_matrix.sv

//--- Makefile
VERILATOR  = verilator
TOP        = tb_led_matrix
FILELIST   = sim.f
BUILD_DIR  = obj_dir
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
PASS_MSG   = Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/led_matrix_testdata.txt
// count, then the bytes sent on the uart line, opcode first
// count 00 checks one whole frame, next byte is the test id; ff ends the list
03 04 0a 5c
00 01
05 03 00 00 0f 0f
05 03 0f 07 03 c5
05 03 0f 00 0c 30
05 03 00 07 05 aa
05 03 06 02 06 9a
05 03 0a 04 01 23
00 02
02 01 01
00 03
02 01 07
00 04
02 02 0a
00 05
02 02 0f
00 06
01 7e
00 07
03 04 03 e1
00 08
ff
